// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_width = 4;
	localparam int dmem_depth = 64;
	localparam int dmem_addr_width = $clog2(dmem_depth);

	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;

	typedef enum logic [2:0] {
		cls_none,
		cls_lui,
		cls_auipc,
		cls_addi,
		cls_add,
		cls_lw,
		cls_sw
	} op_class_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_i_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} inst_s_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_u_t;

	typedef union packed {
		inst_r_t r;
		inst_i_t i;
		inst_s_t s;
		inst_u_t u;
	} rv_inst_t;

endpackage

`default_nettype wire

// ==== src/issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface issue_if;

	logic valid;
	logic ready;
	core_pkg::op_class_t op_class;
	logic [core_pkg::xlen-1:0] pc;
	logic [core_pkg::xlen-1:0] src1; // result when used between execute and mem.
	logic [core_pkg::xlen-1:0] src2; // store data between execute and mem.
	logic [core_pkg::xlen-1:0] imm;
	logic [core_pkg::reg_addr_width-1:0] rd;
	logic reg_wen;

	modport decode (
		output valid, op_class, pc, src1, src2, imm, rd, reg_wen,
		input ready
	);

	modport execute (
		input valid, op_class, pc, src1, src2, imm, rd, reg_wen,
		output ready
	);

endinterface

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input logic clock,
	input logic [core_pkg::reg_addr_width-1:0] rs1,
	input logic [core_pkg::reg_addr_width-1:0] rs2,
	output logic [core_pkg::xlen-1:0] data1,
	output logic [core_pkg::xlen-1:0] data2,
	input logic wb_en,
	input logic [core_pkg::reg_addr_width-1:0] wb_rd,
	input logic [core_pkg::xlen-1:0] wb_data
);

	logic [core_pkg::xlen-1:0] regs [2**core_pkg::reg_addr_width];

	always_ff @(posedge clock) begin
		if (wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// write-first, so a read in the writeback cycle sees the new value.
	always_comb begin
		if (rs1 == '0) begin
			data1 = '0;
		end else if (wb_en && wb_rd == rs1) begin
			data1 = wb_data;
		end else begin
			data1 = regs[rs1];
		end
	end

	always_comb begin
		if (rs2 == '0) begin
			data2 = '0;
		end else if (wb_en && wb_rd == rs2) begin
			data2 = wb_data;
		end else begin
			data2 = regs[rs2];
		end
	end

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input logic clock,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic [core_pkg::xlen-1:0] in_pc,
	input logic [core_pkg::xlen-1:0] in_inst,
	output logic [core_pkg::reg_addr_width-1:0] rs1,
	output logic [core_pkg::reg_addr_width-1:0] rs2,
	input logic [core_pkg::xlen-1:0] rf_data1,
	input logic [core_pkg::xlen-1:0] rf_data2,
	input logic [core_pkg::reg_addr_width-1:0] ex_rd,
	input logic ex_wen,
	input logic ex_is_load,
	input logic ex_valid,
	input logic [core_pkg::xlen-1:0] ex_value,
	input logic [core_pkg::reg_addr_width-1:0] mem_rd,
	input logic mem_wen,
	input logic mem_busy_load,
	input logic [core_pkg::xlen-1:0] mem_value,
	issue_if.decode issue
);

	core_pkg::rv_inst_t inst;
	core_pkg::op_class_t op_class;
	logic [core_pkg::xlen-1:0] imm;
	logic [core_pkg::reg_addr_width-1:0] rd;
	logic need_rs1;
	logic need_rs2;
	logic reg_wen;
	logic issue_hit1, issue_hit2;
	logic ex_hit1, ex_hit2;
	logic mem_hit1, mem_hit2;
	logic stall;
	logic accept;
	logic [core_pkg::xlen-1:0] src1;
	logic [core_pkg::xlen-1:0] src2;

	assign inst = in_inst;
	assign rs1 = inst.r.rs1[core_pkg::reg_addr_width-1:0];
	assign rs2 = inst.r.rs2[core_pkg::reg_addr_width-1:0];
	assign rd = inst.r.rd[core_pkg::reg_addr_width-1:0];

	always_comb begin
		op_class = core_pkg::cls_none; // anything unrecognized is a no-op.
		case (inst.r.opcode)
			core_pkg::op_lui: op_class = core_pkg::cls_lui;
			core_pkg::op_auipc: op_class = core_pkg::cls_auipc;
			core_pkg::op_imm: begin
				if (inst.i.funct3 == 3'b000) op_class = core_pkg::cls_addi;
			end
			core_pkg::op_reg: begin
				if (inst.r.funct3 == 3'b000 && inst.r.funct7 == 7'b0) op_class = core_pkg::cls_add;
			end
			core_pkg::op_load: begin
				if (inst.i.funct3 == 3'b010) op_class = core_pkg::cls_lw;
			end
			core_pkg::op_store: begin
				if (inst.s.funct3 == 3'b010) op_class = core_pkg::cls_sw;
			end
			default: op_class = core_pkg::cls_none;
		endcase
	end

	always_comb begin
		case (op_class)
			core_pkg::cls_lui, core_pkg::cls_auipc: imm = {inst.u.imm, 12'b0};
			core_pkg::cls_sw: imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
			default: imm = {{20{inst.i.imm[11]}}, inst.i.imm};
		endcase
	end

	assign need_rs1 = op_class inside {core_pkg::cls_addi, core_pkg::cls_add,
		core_pkg::cls_lw, core_pkg::cls_sw};
	assign need_rs2 = op_class inside {core_pkg::cls_add, core_pkg::cls_sw};
	// rd of zero clears reg_wen, so x0 never matches a producer below.
	assign reg_wen = (op_class inside {core_pkg::cls_lui, core_pkg::cls_auipc,
		core_pkg::cls_addi, core_pkg::cls_add, core_pkg::cls_lw}) && rd != '0;

	// the entry still in the issue register has no value yet.
	assign issue_hit1 = issue.valid & issue.reg_wen & need_rs1 & (issue.rd == rs1);
	assign issue_hit2 = issue.valid & issue.reg_wen & need_rs2 & (issue.rd == rs2);
	assign ex_hit1 = ex_valid & ex_wen & need_rs1 & (ex_rd == rs1);
	assign ex_hit2 = ex_valid & ex_wen & need_rs2 & (ex_rd == rs2);
	assign mem_hit1 = mem_wen & need_rs1 & (mem_rd == rs1);
	assign mem_hit2 = mem_wen & need_rs2 & (mem_rd == rs2);

	assign stall = issue_hit1 | issue_hit2
		| (ex_is_load & (ex_hit1 | ex_hit2))
		| (mem_busy_load & (mem_hit1 | mem_hit2)); // load-use.

	assign src1 = ex_hit1 ? ex_value : mem_hit1 ? mem_value : rf_data1; // youngest first.
	assign src2 = ex_hit2 ? ex_value : mem_hit2 ? mem_value : rf_data2;

	assign in_ready = (~issue.valid | issue.ready) & ~stall;
	assign accept = in_valid & in_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			issue.valid <= 1'b0;
		end else if (accept) begin
			issue.valid <= 1'b1;
		end else if (issue.ready) begin
			issue.valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			issue.op_class <= op_class;
			issue.pc <= in_pc;
			issue.src1 <= src1;
			issue.src2 <= src2;
			issue.imm <= imm;
			issue.rd <= rd;
			issue.reg_wen <= reg_wen;
		end
	end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input logic clock,
	input logic reset,
	issue_if.execute issue,
	issue_if.decode result,
	output logic [core_pkg::reg_addr_width-1:0] ex_rd,
	output logic ex_wen,
	output logic ex_is_load,
	output logic ex_valid,
	output logic [core_pkg::xlen-1:0] ex_value
);

	logic [core_pkg::xlen-1:0] alu;
	logic accept;

	always_comb begin
		case (issue.op_class)
			core_pkg::cls_lui: alu = issue.imm;
			core_pkg::cls_auipc: alu = issue.pc + issue.imm;
			core_pkg::cls_addi, core_pkg::cls_lw, core_pkg::cls_sw: alu = issue.src1 + issue.imm;
			core_pkg::cls_add: alu = issue.src1 + issue.src2;
			default: alu = '0;
		endcase
	end

	assign issue.ready = ~result.valid | result.ready; // hold under back-pressure.
	assign accept = issue.valid & issue.ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			result.valid <= 1'b0;
		end else if (accept) begin
			result.valid <= 1'b1;
		end else if (result.ready) begin
			result.valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			result.op_class <= issue.op_class;
			result.pc <= issue.pc;
			result.src1 <= alu; // ALU result or address.
			result.src2 <= issue.src2; // store data.
			result.imm <= issue.imm;
			result.rd <= issue.rd;
			result.reg_wen <= issue.reg_wen;
		end
	end

	assign ex_valid = result.valid;
	assign ex_rd = result.rd;
	assign ex_wen = result.reg_wen;
	assign ex_is_load = result.op_class == core_pkg::cls_lw;
	assign ex_value = result.src1;

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input logic clock,
	input logic reset,
	issue_if.execute result,
	output logic [core_pkg::reg_addr_width-1:0] mem_rd,
	output logic mem_wen,
	output logic mem_busy_load,
	output logic [core_pkg::xlen-1:0] mem_value,
	output logic wb_en,
	output logic [core_pkg::reg_addr_width-1:0] wb_rd,
	output logic [core_pkg::xlen-1:0] wb_data
);

	logic [core_pkg::xlen-1:0] dmem [core_pkg::dmem_depth];
	logic [core_pkg::dmem_addr_width-1:0] addr;
	logic [core_pkg::dmem_addr_width-1:0] ld_addr;
	logic [core_pkg::reg_addr_width-1:0] ld_rd;
	logic ld_wen;
	logic busy;
	logic accept;

	assign addr = result.src1[core_pkg::dmem_addr_width+1:2]; // word address.
	assign result.ready = ~busy; // no accept during the first load cycle.
	assign accept = result.valid & result.ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			wb_en <= 1'b0;
		end else begin
			wb_en <= 1'b0;
			if (busy) begin
				busy <= 1'b0;
				wb_en <= ld_wen;
			end else if (accept) begin
				if (result.op_class == core_pkg::cls_lw) begin
					busy <= 1'b1;
				end else begin
					wb_en <= result.reg_wen; // stores and no-ops carry no reg_wen.
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (busy) begin
			wb_rd <= ld_rd;
			wb_data <= dmem[ld_addr];
		end else if (accept) begin
			ld_addr <= addr;
			ld_rd <= result.rd;
			ld_wen <= result.reg_wen;
			wb_rd <= result.rd;
			wb_data <= result.src1;
			if (result.op_class == core_pkg::cls_sw) begin
				dmem[addr] <= result.src2;
			end
		end
	end

	// a busy load names its rd but has no value yet.
	assign mem_busy_load = busy;
	assign mem_rd = busy ? ld_rd : wb_rd;
	assign mem_wen = busy ? ld_wen : wb_en;
	assign mem_value = wb_data;

endmodule

`default_nettype wire

// ==== src/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top (
	input logic clock,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic [31:0] in_pc,
	input logic [31:0] in_inst,
	output logic wb_en,
	output logic [3:0] wb_rd,
	output logic [31:0] wb_data
);

	issue_if issue_bus ();
	issue_if result_bus ();

	logic [3:0] rs1, rs2;
	logic [31:0] rf_data1, rf_data2;
	logic [3:0] ex_rd;
	logic ex_wen, ex_is_load, ex_valid;
	logic [31:0] ex_value;
	logic [3:0] mem_rd;
	logic mem_wen, mem_busy_load;
	logic [31:0] mem_value;

	decode_stage u_decode (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_pc(in_pc),
		.in_inst(in_inst),
		.rs1(rs1),
		.rs2(rs2),
		.rf_data1(rf_data1),
		.rf_data2(rf_data2),
		.ex_rd(ex_rd),
		.ex_wen(ex_wen),
		.ex_is_load(ex_is_load),
		.ex_valid(ex_valid),
		.ex_value(ex_value),
		.mem_rd(mem_rd),
		.mem_wen(mem_wen),
		.mem_busy_load(mem_busy_load),
		.mem_value(mem_value),
		.issue(issue_bus.decode)
	);

	execute_stage u_execute (
		.clock(clock),
		.reset(reset),
		.issue(issue_bus.execute),
		.result(result_bus.decode),
		.ex_rd(ex_rd),
		.ex_wen(ex_wen),
		.ex_is_load(ex_is_load),
		.ex_valid(ex_valid),
		.ex_value(ex_value)
	);

	mem_stage u_mem (
		.clock(clock),
		.reset(reset),
		.result(result_bus.execute),
		.mem_rd(mem_rd),
		.mem_wen(mem_wen),
		.mem_busy_load(mem_busy_load),
		.mem_value(mem_value),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	reg_file u_reg_file (
		.clock(clock),
		.rs1(rs1),
		.rs2(rs2),
		.data1(rf_data1),
		.data2(rf_data2),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

endmodule

`default_nettype wire

// ==== bench/core_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_chk (
	input logic clock,
	input logic reset,
	input logic in_ready,
	input logic wb_en,
	input logic [3:0] wb_rd,
	input logic [31:0] wb_data
);

	// the pipeline is empty when reset drops, so decode must accept.
	ready_on_reset_exit: assert property (@(posedge clock) $fell(reset) |-> in_ready)
		else $error("in_ready low on the first cycle after reset.");

	no_x0_writeback: assert property (@(posedge clock) disable iff (reset)
		wb_en |-> wb_rd != 4'd0)
		else $error("writeback reported for x0.");

	known_writeback: assert property (@(posedge clock) disable iff (reset)
		wb_en |-> !$isunknown({wb_rd, wb_data}))
		else $error("writeback index or data unknown.");

endmodule

`default_nettype wire

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	localparam int wait_limit = 200;

	logic clock;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic [31:0] in_pc;
	logic [31:0] in_inst;
	logic wb_en;
	logic [3:0] wb_rd;
	logic [31:0] wb_data;

	logic [31:0] stim_pc [$];
	logic [31:0] stim_inst [$];
	logic [3:0] exp_rd [$];
	logic [31:0] exp_data [$];

	core_top DUT (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_pc(in_pc),
		.in_inst(in_inst),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	bind core_top core_chk u_chk (.clock(clock), .reset(reset), .in_ready(in_ready),
		.wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data));

	always #4 clock = ~clock;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic load_golden();
		int fd;
		int n;
		string line;
		string tag;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("bench/core_golden.txt", "r");
		assert (fd != 0) else abort_run("cannot open bench/core_golden.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%s %h %h", tag, a, b); // comment lines fail the match.
			if (n == 3 && tag == "I") begin
				stim_pc.push_back(a);
				stim_inst.push_back(b);
			end else if (n == 3 && tag == "W") begin
				exp_rd.push_back(a[3:0]);
				exp_data.push_back(b);
			end
		end
		$fclose(fd);
	endtask

	// holds the instruction until decode takes it.
	task automatic issue_inst(input logic [31:0] pc, input logic [31:0] inst);
		int waited;
		waited = 0;
		@(negedge clock);
		in_valid = 1'b1;
		in_pc = pc;
		in_inst = inst;
		#1;
		while (!in_ready) begin
			waited++;
			assert (waited < wait_limit)
				else abort_run($sformatf("in_ready stayed low for pc %h", pc));
			@(negedge clock);
			#1;
		end
		@(posedge clock);
	endtask

	always @(negedge clock) begin
		if (!reset && wb_en) begin
			assert (exp_rd.size() > 0)
				else abort_run("writeback seen after all expected writebacks");
			assert (wb_rd == exp_rd[0]) else abort_run($sformatf(
				"ERR %0t wb_rd got %0d expected %0d", $time, wb_rd, exp_rd[0]));
			assert (wb_data == exp_data[0]) else abort_run($sformatf(
				"ERR %0t wb_data got %h expected %h", $time, wb_data, exp_data[0]));
			void'(exp_rd.pop_front());
			void'(exp_data.pop_front());
		end
	end

	initial begin
		int waited;
		int k;
		clock = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_pc = '0;
		in_inst = '0;
		load_golden();
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (k = 0; k < stim_pc.size(); k++) begin
			issue_inst(stim_pc[k], stim_inst[k]);
		end
		@(negedge clock);
		in_valid = 1'b0;
		waited = 0;
		while (exp_rd.size() > 0) begin
			waited++;
			assert (waited < wait_limit)
				else abort_run("expected writebacks never arrived");
			@(negedge clock);
		end
		repeat (20) @(negedge clock); // extra writebacks trip the monitor.
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
src/core_pkg.sv
src/issue_if.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_stage.sv
src/core_top.sv
bench/core_chk.sv
bench/core_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb -f all.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vcore_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qxF "=== PASS ==="; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== bench/core_golden.txt ====
# I <pc hex> <instruction hex>: instruction fed to the core in order
# W <rd hex> <data hex>: expected register write, in program order
I 00000000 00500093
I 00000004 12345137
I 00000008 00001197
I 0000000c 00108233
I 00000010 001202b3
I 00000014 00428333
I 00000018 00602423
I 0000001c 00802383
I 00000020 00738433
I 00000024 00708013
I 00000028 0000000b
I 0000002c fff10493
I 00000030 00902823
I 00000034 01002503
I 00000038 00150593
I 0000003c 00358633
W 1 00000005
W 2 12345000
W 3 00001008
W 4 0000000a
W 5 0000000f
W 6 00000019
W 7 00000019
W 8 00000032
W 9 12344fff
W a 12344fff
W b 12345000
W c 12346008
